// ==== matrix_pkg.sv ====
// shared geometry, address types and opcodes for the LED matrix command front end
// every RTL module takes these with a wildcard import in its header
package matrix_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // matrix geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_ROWS        = 32;
    localparam int NUM_COLS        = 64;
    localparam int BYTES_PER_PIXEL = 3;

    localparam int FB_BYTES   = NUM_ROWS * NUM_COLS * BYTES_PER_PIXEL;
    // distance in bytes between the first pixels of two neighbouring rows
    localparam int ROW_STRIDE = NUM_COLS * BYTES_PER_PIXEL;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // derived widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ROW_BITS     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
    localparam int COL_BITS     = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;
    localparam int PIXEL_BITS   = (BYTES_PER_PIXEL > 1) ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam int FB_ADDR_BITS = $clog2(FB_BYTES);

    // the column number arrives little endian, one byte per strobe
    localparam int COL_BYTES    = (COL_BITS + 7) / 8;
    localparam int COL_CNT_BITS = (COL_BYTES > 1) ? $clog2(COL_BYTES) : 1;

    typedef logic [ROW_BITS-1:0]     row_addr_t;
    typedef logic [COL_BITS-1:0]     col_addr_t;
    typedef logic [PIXEL_BITS-1:0]   pixel_byte_t;
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] OP_WRITE_PIXEL = 8'h10;
    localparam logic [7:0] OP_FILL        = 8'h20;

endpackage

// ==== fb_sweep_counter.sv ====
// walks every framebuffer byte once after a start pulse, one byte per cycle
// byte_sel tracks the byte index inside the current pixel without a divider
`timescale 1ns/1ps

module fb_sweep_counter import matrix_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sweep_start,
    output fb_addr_t    addr,
    output pixel_byte_t byte_sel,
    output logic        busy_count,
    output logic        last
);

    // final address of the sweep, busy_count drops right after it
    assign last = busy_count && (addr == fb_addr_t'(FB_BYTES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_count <= 1'b0;
            addr       <= '0;
            byte_sel   <= '0;
        end else if (sweep_start) begin
            busy_count <= 1'b1;
            addr       <= '0;
            byte_sel   <= '0;
        end else if (busy_count) begin
            if (last) begin
                busy_count <= 1'b0;
            end else begin
                addr <= addr + 1'b1;
                // inner level wraps once per pixel
                if (byte_sel == pixel_byte_t'(BYTES_PER_PIXEL - 1)) begin
                    byte_sel <= '0;
                end else begin
                    byte_sel <= byte_sel + 1'b1;
                end
            end
        end
    end

    // a restart in the middle of a sweep would skip part of the framebuffer
    a_no_restart : assert property (@(posedge clk) disable iff (reset)
        sweep_start |-> !busy_count);

endmodule

// ==== cmd_write_pixel.sv ====
// write pixel handler: row byte, little-endian column bytes, then the colour bytes MSB first
// each colour byte is handed to the framebuffer by toggling ram_access_start
`timescale 1ns/1ps

module cmd_write_pixel import matrix_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [7:0]  data_in,
    output row_addr_t   row,
    output col_addr_t   column,
    output pixel_byte_t pixel,
    output logic [7:0]  data_out,
    output logic        ram_write_enable,
    output logic        ram_access_start,
    output logic        done
);

    typedef enum logic [1:0] {
        ST_ROW,
        ST_COL,
        ST_PIX,
        ST_DONE
    } wp_state_t;

    wp_state_t                state;
    logic [COL_CNT_BITS-1:0]  col_count;
    pixel_byte_t              pix_count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_ROW;
            col_count        <= '0;
            pix_count        <= '0;
            pixel            <= '0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done             <= 1'b0;
        end else begin
            case (state)
                ST_ROW: begin
                    if (enable) begin
                        col_count <= COL_CNT_BITS'(COL_BYTES - 1);
                        state     <= ST_COL;
                    end
                end
                ST_COL: begin
                    if (enable) begin
                        if (col_count == '0) begin
                            // column complete, the next strobe is the top colour byte
                            pix_count        <= pixel_byte_t'(BYTES_PER_PIXEL - 1);
                            ram_write_enable <= 1'b1;
                            state            <= ST_PIX;
                        end else begin
                            col_count <= col_count - 1'b1;
                        end
                    end
                end
                ST_PIX: begin
                    if (enable) begin
                        pixel            <= pix_count;
                        ram_access_start <= !ram_access_start;
                        if (pix_count == '0) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            pix_count <= pix_count - 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    // the last byte is written while we sit here, so the
                    // write enable may only drop afterwards
                    done             <= 1'b0;
                    ram_write_enable <= 1'b0;
                    state            <= ST_ROW;
                end
                default: state <= ST_ROW;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // captured row, column and colour byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (enable) begin
            case (state)
                ST_ROW: row <= row_addr_t'(data_in);
                ST_COL: begin
                    // first column byte holds bits 7:0, later bytes go higher
                    for (int i = 0; i < COL_BITS; i++) begin
                        if (i / 8 == COL_BYTES - 1 - int'(col_count)) begin
                            column[i] <= data_in[i % 8];
                        end
                    end
                end
                ST_PIX: data_out <= data_in;
                default: ;
            endcase
        end
    end

    a_pixel_range : assert property (@(posedge clk) disable iff (reset)
        pixel <= pixel_byte_t'(BYTES_PER_PIXEL - 1));

endmodule

// ==== cmd_fill.sv ====
// fill handler: collects one colour, MSB first, then sweeps it over the whole framebuffer
// the sweep itself comes from fb_sweep_counter, this block supplies the data
`timescale 1ns/1ps

module cmd_fill import matrix_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [7:0]  data_in,
    input  pixel_byte_t byte_sel,
    input  logic        busy_count,
    input  logic        last,
    output logic        sweep_start,
    output logic        fill_write,
    output logic [7:0]  fill_data,
    output logic        done
);

    typedef enum logic [1:0] {
        ST_COLLECT,
        ST_SWEEP,
        ST_DONE
    } fill_state_t;

    fill_state_t  state;
    pixel_byte_t  colour_idx;
    logic [7:0]   colour [BYTES_PER_PIXEL];

    // strobes during the sweep are dropped since state is not ST_COLLECT
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_COLLECT;
            colour_idx  <= pixel_byte_t'(BYTES_PER_PIXEL - 1);
            sweep_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            case (state)
                ST_COLLECT: begin
                    if (enable) begin
                        if (colour_idx == '0) begin
                            sweep_start <= 1'b1;
                            state       <= ST_SWEEP;
                        end else begin
                            colour_idx <= colour_idx - 1'b1;
                        end
                    end
                end
                ST_SWEEP: begin
                    sweep_start <= 1'b0;
                    if (last) begin
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    done       <= 1'b0;
                    colour_idx <= pixel_byte_t'(BYTES_PER_PIXEL - 1);
                    state      <= ST_COLLECT;
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

    // colour bytes land at the index they will be written to
    always_ff @(posedge clk) begin
        if (enable && state == ST_COLLECT) begin
            colour[colour_idx] <= data_in;
        end
    end

    assign fill_write = busy_count && (state == ST_SWEEP);
    assign fill_data  = colour[byte_sel];

endmodule

// ==== cmd_dispatch.sv ====
// opcode decoder: the first strobed byte picks a handler, later strobes go to that handler
// until it reports done; unknown opcodes raise a one-cycle error
`timescale 1ns/1ps

module cmd_dispatch import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    input  logic       wp_done,
    input  logic       fill_done,
    output logic       wp_enable,
    output logic       fill_enable,
    output logic       busy,
    output logic       cmd_done,
    output logic       cmd_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WP,
        ST_FILL
    } disp_state_t;

    disp_state_t state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // routing FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (enable) begin
                        case (data_in)
                            OP_WRITE_PIXEL: state <= ST_WP;
                            OP_FILL:        state <= ST_FILL;
                            default:        cmd_error <= 1'b1;
                        endcase
                    end
                end
                ST_WP: begin
                    if (wp_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FILL: begin
                    if (fill_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // strobes pass straight through, so the handler sees a byte in its own cycle
    assign wp_enable   = enable && (state == ST_WP);
    assign fill_enable = enable && (state == ST_FILL);

    assign busy     = (state != ST_IDLE);
    assign cmd_done = wp_done || fill_done;

    // a done from a handler that was never started means the two sides lost step
    a_done_not_idle : assert property (@(posedge clk) disable iff (reset)
        (state == ST_IDLE) |-> !(wp_done || fill_done));

endmodule

// ==== framebuffer_ram.sv ====
// byte-wide framebuffer with a toggle-strobed pixel write port, a fill write port
// and a registered read port for the display scanner
`timescale 1ns/1ps

module framebuffer_ram import matrix_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  row_addr_t   row,
    input  col_addr_t   column,
    input  pixel_byte_t pixel,
    input  logic [7:0]  data_in,
    input  logic        ram_write_enable,
    input  logic        ram_access_start,
    input  logic        fill_write,
    input  fb_addr_t    fill_addr,
    input  logic [7:0]  fill_data,
    input  fb_addr_t    rd_addr,
    output logic [7:0]  rd_data
);

    logic [7:0] mem [FB_BYTES];
    logic       access_q;
    logic       pixel_write;
    fb_addr_t   pixel_addr;

    assign pixel_addr = fb_addr_t'(row) * fb_addr_t'(ROW_STRIDE)
                      + fb_addr_t'(column) * fb_addr_t'(BYTES_PER_PIXEL)
                      + fb_addr_t'(pixel);

    // every edge of the access strobe asks for one byte write
    assign pixel_write = ram_write_enable && (ram_access_start != access_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            access_q <= 1'b0;
        end else begin
            access_q <= ram_access_start;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_write) begin
            mem[pixel_addr] <= data_in;
        end else if (fill_write) begin
            mem[fill_addr] <= fill_data;
        end
        rd_data <= mem[rd_addr];
    end

    // the dispatcher only runs one handler at a time, so the ports never collide
    a_one_writer : assert property (@(posedge clk) disable iff (reset)
        !(pixel_write && fill_write));

endmodule

// ==== matrix_cmd_top.sv ====
// top of the command front end: dispatcher, both handlers, sweep counter and framebuffer
// the host strobes bytes in on enable and watches busy before sending the next command
`timescale 1ns/1ps

module matrix_cmd_top import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    input  fb_addr_t   rd_addr,
    output logic [7:0] rd_data,
    output logic       busy,
    output logic       cmd_done,
    output logic       cmd_error
);

    logic        wp_enable;
    logic        wp_done;
    logic        fill_enable;
    logic        fill_done;

    // write pixel port
    row_addr_t   wp_row;
    col_addr_t   wp_column;
    pixel_byte_t wp_pixel;
    logic [7:0]  wp_data;
    logic        ram_write_enable;
    logic        ram_access_start;

    // fill port and sweep
    logic        sweep_start;
    fb_addr_t    sweep_addr;
    pixel_byte_t byte_sel;
    logic        busy_count;
    logic        sweep_last;
    logic        fill_write;
    logic [7:0]  fill_data;

    cmd_dispatch cmd_dispatch_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .data_in     (data_in),
        .wp_done     (wp_done),
        .fill_done   (fill_done),
        .wp_enable   (wp_enable),
        .fill_enable (fill_enable),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .cmd_error   (cmd_error)
    );

    cmd_write_pixel cmd_write_pixel_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (wp_enable),
        .data_in          (data_in),
        .row              (wp_row),
        .column           (wp_column),
        .pixel            (wp_pixel),
        .data_out         (wp_data),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start),
        .done             (wp_done)
    );

    cmd_fill cmd_fill_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (fill_enable),
        .data_in     (data_in),
        .byte_sel    (byte_sel),
        .busy_count  (busy_count),
        .last        (sweep_last),
        .sweep_start (sweep_start),
        .fill_write  (fill_write),
        .fill_data   (fill_data),
        .done        (fill_done)
    );

    fb_sweep_counter fb_sweep_counter_i (
        .clk         (clk),
        .reset       (reset),
        .sweep_start (sweep_start),
        .addr        (sweep_addr),
        .byte_sel    (byte_sel),
        .busy_count  (busy_count),
        .last        (sweep_last)
    );

    framebuffer_ram framebuffer_ram_i (
        .clk              (clk),
        .reset            (reset),
        .row              (wp_row),
        .column           (wp_column),
        .pixel            (wp_pixel),
        .data_in          (wp_data),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start),
        .fill_write       (fill_write),
        .fill_addr        (sweep_addr),
        .fill_data        (fill_data),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data)
    );

endmodule

// ==== matrix_checker.sv ====
// testbench checker: counts done and error pulses and compares read-back bytes
// prints one line per test and a closing line of counts, the top reads fail_count
`timescale 1ns/1ps

module matrix_checker import matrix_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         cmd_done,
    input  logic         cmd_error,
    input  logic         busy,
    input  logic [7:0]   rd_data,
    input  logic [127:0] test_name,
    input  logic         test_start,
    input  logic         check,
    input  fb_addr_t     check_addr,
    input  logic [7:0]   exp_data,
    input  logic         test_end,
    input  int           exp_done,
    input  int           exp_error,
    input  logic         exp_busy,
    input  logic         report,
    output int           fail_count
);

    int   done_seen;
    int   error_seen;
    logic busy_seen;
    int   test_fails;
    int   tests_run;
    int   tests_failed;
    int   reads;

    always @(posedge clk) begin
        if (reset) begin
            done_seen    = 0;
            error_seen   = 0;
            busy_seen    = 1'b0;
            test_fails   = 0;
            tests_run    = 0;
            tests_failed = 0;
            reads        = 0;
            fail_count   = 0;
        end else begin
            // pulse counters restart with every test
            if (test_start) begin
                done_seen  = 0;
                error_seen = 0;
                busy_seen  = 1'b0;
                test_fails = 0;
            end else begin
                if (cmd_done) done_seen++;
                if (cmd_error) error_seen++;
                if (busy) busy_seen = 1'b1;
            end
            if (check) begin
                reads++;
                if (rd_data !== exp_data) begin
                    $display("FAILED %0s: address %0d expected %02h actual %02h",
                             test_name, check_addr, exp_data, rd_data);
                    test_fails++;
                end
            end
            if (test_end) begin
                if (done_seen != exp_done) begin
                    $display("FAILED %0s: done pulses expected %0d actual %0d",
                             test_name, exp_done, done_seen);
                    test_fails++;
                end
                if (error_seen != exp_error) begin
                    $display("FAILED %0s: error pulses expected %0d actual %0d",
                             test_name, exp_error, error_seen);
                    test_fails++;
                end
                if (busy_seen !== exp_busy) begin
                    $display("FAILED %0s: busy raised expected %0d actual %0d",
                             test_name, exp_busy, busy_seen);
                    test_fails++;
                end
                tests_run++;
                if (test_fails == 0) begin
                    $display("pass  %0s", test_name);
                end else begin
                    $display("test %0s had %0d failing checks", test_name, test_fails);
                    tests_failed++;
                end
                fail_count += test_fails;
            end
            if (report) begin
                $display("tests %0d, passed %0d, failed %0d, read-backs %0d, mismatches %0d",
                         tests_run, tests_run - tests_failed, tests_failed, reads, fail_count);
            end
        end
    end

endmodule

// ==== tb_matrix_cmd.sv ====
// testbench for the matrix command front end: builds a table of commands with the
// expected read-back bytes, applies it in a loop and lets matrix_checker compare
`timescale 1ns/1ps

module tb_matrix_cmd import matrix_pkg::*; ();

    localparam int NUM_TESTS      = 7;
    localparam int MAX_BYTES      = 8 + 2 * BYTES_PER_PIXEL;
    localparam int MAX_READS      = 4 + 3 * BYTES_PER_PIXEL;
    localparam int TIMEOUT_CYCLES = 3 * FB_BYTES + 4000;
    localparam int PW             = 8 * BYTES_PER_PIXEL;

    logic         clk;
    logic         reset;
    logic         enable;
    logic [7:0]   data_in;
    fb_addr_t     rd_addr;
    logic [7:0]   rd_data;
    logic         busy;
    logic         cmd_done;
    logic         cmd_error;
    logic [127:0] test_name;
    logic         test_start;
    logic         check;
    fb_addr_t     check_addr;
    logic [7:0]   exp_data;
    logic         test_end;
    logic         report;
    int           exp_done;
    int           exp_error;
    logic         exp_busy;
    int           fail_count;
    int           cycles;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table and memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    string        t_name [NUM_TESTS];
    logic [7:0]   t_bytes [NUM_TESTS][MAX_BYTES];
    int           t_nbytes [NUM_TESTS];
    logic         t_wait_busy [NUM_TESTS];
    int           t_done [NUM_TESTS];
    int           t_error [NUM_TESTS];
    fb_addr_t     t_rd_addr [NUM_TESTS][MAX_READS];
    logic [7:0]   t_rd_data [NUM_TESTS][MAX_READS];
    int           t_nreads [NUM_TESTS];
    logic [7:0]   shadow [FB_BYTES];
    int           cur;

    matrix_cmd_top matrix_cmd_top_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .data_in   (data_in),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .cmd_done  (cmd_done),
        .cmd_error (cmd_error)
    );

    matrix_checker matrix_checker_i (
        .clk        (clk),
        .reset      (reset),
        .cmd_done   (cmd_done),
        .cmd_error  (cmd_error),
        .busy       (busy),
        .rd_data    (rd_data),
        .test_name  (test_name),
        .test_start (test_start),
        .check      (check),
        .check_addr (check_addr),
        .exp_data   (exp_data),
        .test_end   (test_end),
        .exp_done   (exp_done),
        .exp_error  (exp_error),
        .exp_busy   (exp_busy),
        .report     (report),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int pixel_base(input int r, input int c);
        return r * NUM_COLS * BYTES_PER_PIXEL + c * BYTES_PER_PIXEL;
    endfunction

    function automatic logic [PW-1:0] random_colour();
        logic [PW-1:0] col;
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            col[8*k +: 8] = 8'($urandom);
        end
        return col;
    endfunction

    function automatic logic [127:0] name_bits(input string s);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < s.len(); i++) begin
            r = {r[119:0], s.getc(i)};
        end
        return r;
    endfunction

    task automatic open_entry(input string name, input logic wait_busy, input int n_done,
                              input int n_error);
        t_name[cur]      = name;
        t_wait_busy[cur] = wait_busy;
        t_done[cur]      = n_done;
        t_error[cur]     = n_error;
        t_nbytes[cur]    = 0;
        t_nreads[cur]    = 0;
    endtask

    task automatic add_byte(input logic [7:0] b);
        t_bytes[cur][t_nbytes[cur]] = b;
        t_nbytes[cur]++;
    endtask

    // expected byte comes from the model as it stands after this entry
    task automatic add_read(input int a);
        t_rd_addr[cur][t_nreads[cur]] = fb_addr_t'(a);
        t_rd_data[cur][t_nreads[cur]] = shadow[a];
        t_nreads[cur]++;
    endtask

    // opcode, row, little-endian column, colour MSB first landing at the top byte index
    task automatic build_write_pixel(input string name, input int r, input int c,
                                     input logic [PW-1:0] colour);
        open_entry(name, 1'b1, 1, 0);
        add_byte(OP_WRITE_PIXEL);
        add_byte(8'(r));
        for (int k = 0; k < COL_BYTES; k++) begin
            add_byte(8'(c >> (8 * k)));
        end
        for (int k = BYTES_PER_PIXEL - 1; k >= 0; k--) begin
            add_byte(colour[8*k +: 8]);
            shadow[pixel_base(r, c) + k] = colour[8*k +: 8];
        end
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            add_read(pixel_base(r, c) + k);
        end
    endtask

    task automatic build_fill(input string name, input logic [PW-1:0] colour, input int junk);
        open_entry(name, 1'b1, 1, 0);
        add_byte(OP_FILL);
        for (int k = BYTES_PER_PIXEL - 1; k >= 0; k--) begin
            add_byte(colour[8*k +: 8]);
        end
        for (int a = 0; a < FB_BYTES; a++) begin
            shadow[a] = colour[8*(a % BYTES_PER_PIXEL) +: 8];
        end
        // bytes sent while the sweep runs, both opcodes among them, must vanish
        for (int j = 0; j < junk; j++) begin
            if (j == 0) begin
                add_byte(OP_WRITE_PIXEL);
            end else if (j == 1) begin
                add_byte(OP_FILL);
            end else begin
                add_byte(8'($urandom));
            end
        end
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            add_read(k);
            add_read(FB_BYTES - BYTES_PER_PIXEL + k);
        end
        for (int j = 0; j < 4; j++) begin
            add_read(int'($urandom_range(FB_BYTES - 1)));
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        repeat ($urandom_range(2)) @(negedge clk);
        enable  = 1'b1;
        data_in = b;
        @(negedge clk);
        enable  = 1'b0;
    endtask

    task automatic build_table();
        int r;
        int c;
        int first_base;
        cur = 0;
        r = int'($urandom_range(NUM_ROWS - 1));
        c = int'($urandom_range(NUM_COLS - 1));
        first_base = pixel_base(r, c);
        build_write_pixel("wp_random", r, c, random_colour());
        cur = 1;
        open_entry("bad_opcode", 1'b0, 0, 1);
        add_byte(8'hA5);
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            add_read(first_base + k);
        end
        cur = 2;
        build_fill("fill", random_colour(), 0);
        cur = 3;
        // keep both neighbours inside the same row
        r = int'($urandom_range(NUM_ROWS - 1));
        c = 1 + int'($urandom_range(NUM_COLS - 3));
        build_write_pixel("wp_after_fill", r, c, random_colour());
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            add_read(pixel_base(r, c) - BYTES_PER_PIXEL + k);
            add_read(pixel_base(r, c) + BYTES_PER_PIXEL + k);
        end
        cur = 4;
        build_fill("fill_busy_drop", random_colour(), 4);
        cur = 5;
        build_write_pixel("wp_first_pixel", 0, 0, random_colour());
        add_read(BYTES_PER_PIXEL);
        cur = 6;
        build_write_pixel("wp_last_pixel", NUM_ROWS - 1, NUM_COLS - 1, random_colour());
        add_read(FB_BYTES - BYTES_PER_PIXEL - 1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset      = 1'b1;
        enable     = 1'b0;
        data_in    = '0;
        rd_addr    = '0;
        test_name  = '0;
        test_start = 1'b0;
        check      = 1'b0;
        check_addr = '0;
        exp_data   = '0;
        test_end   = 1'b0;
        report     = 1'b0;
        exp_done   = 0;
        exp_error  = 0;
        exp_busy   = 1'b0;
        void'($urandom(32'h3215_e1e2));
        build_table();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_name  = name_bits(t_name[t]);
            test_start = 1'b1;
            @(negedge clk);
            test_start = 1'b0;
            for (int i = 0; i < t_nbytes[t]; i++) begin
                send_byte(t_bytes[t][i]);
            end
            if (t_wait_busy[t]) begin
                while (busy) @(negedge clk);
            end else begin
                repeat (4) @(negedge clk);
            end
            // read data is registered, so compare one cycle after the address
            for (int i = 0; i < t_nreads[t]; i++) begin
                rd_addr = t_rd_addr[t][i];
                @(negedge clk);
                check_addr = t_rd_addr[t][i];
                exp_data   = t_rd_data[t][i];
                check      = 1'b1;
                @(negedge clk);
                check      = 1'b0;
            end
            exp_done  = t_done[t];
            exp_error = t_error[t];
            // only a valid opcode raises busy
            exp_busy  = t_wait_busy[t];
            test_end  = 1'b1;
            @(negedge clk);
            test_end  = 1'b0;
        end
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // two fills dominate the run time, the limit leaves room for a third
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation hung, no verdict after %0d cycles", cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
matrix_pkg.sv
fb_sweep_counter.sv
cmd_write_pixel.sv
cmd_fill.sv
cmd_dispatch.sv
framebuffer_ram.sv
matrix_cmd_top.sv
matrix_checker.sv
tb_matrix_cmd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_matrix_cmd -o tb_sim
output=$(./obj_dir/tb_sim)
echo "$output"
if grep -q "TB PASSED" <<< "$output"; then
    exit 0
fi
exit 1
